// ==== hdl/cmpEdgeCounter.sv ====
`timescale 1ns/1ps

module cmpEdgeCounter #(
    parameter int countWidth = 8
) (
    input  logic clk,
    input  logic reset,
    input  logic cmp,
    input  logic measureEnable,
    input  logic chopPolarity,
    input  logic clearCounts,
    input  logic chopToggle,
    output logic cmpSync,
    output logic [countWidth-1:0] tmpCount1,
    output logic [countWidth-1:0] tmpCount2,
    output logic cmpP1,
    output logic cmpP2
);

    logic cmpMeta;
    logic cmpPrev;
    logic cmpRise;

    // Two-flop synchronizer for the comparator
    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            cmpMeta <= 1'b0;
            cmpSync <= 1'b0;
            cmpPrev <= 1'b0;
        end else begin
            cmpMeta <= cmp;
            cmpSync <= cmpMeta;
            cmpPrev <= cmpSync;
        end
    end

    assign cmpRise = cmpSync && !cmpPrev;

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            tmpCount1 <= '0;
            tmpCount2 <= '0;
        end else if (clearCounts) begin
            tmpCount1 <= '0;
            tmpCount2 <= '0;
        end else if (measureEnable && cmpRise) begin
            // Saturate rather than wrap
            if (chopPolarity) begin
                if (tmpCount1 != '1) tmpCount1 <= tmpCount1 + 1'b1;
            end else begin
                if (tmpCount2 != '1) tmpCount2 <= tmpCount2 + 1'b1;
            end
        end
    end

    // Chopper follows the comparator in the window, the stepper outside it
    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            cmpP1 <= 1'b0;
        end else if (measureEnable ? cmpRise : chopToggle) begin
            cmpP1 <= !cmpP1;
        end
    end

    assign cmpP2 = !cmpP1;

endmodule

// ==== hdl/diodeStepper.sv ====
`timescale 1ns/1ps

module diodeStepper
    import tempSensePkg::*;
(
    input  logic clk,
    input  logic reset,
    input  logic stepStart,
    input  logic cmpSync,
    input  parentState_t phase,
    output logic PI1,
    output logic PI2,
    output logic PII1,
    output logic PII2,
    output logic PA,
    output logic PB,
    output logic PC,
    output logic PD,
    output logic srcN,
    output logic snk,
    output logic roundDone,
    output logic ptatStepDone,
    output logic chopToggle
);

    childState_t state;
    childState_t stateNext;
    childState_t afterBlank;
    childState_t afterNext;
    logic hCharged;
    logic hChargedNext;
    logic [stepCountWidth-1:0] stepCount;
    logic [stepCountWidth-1:0] stepLen;
    logic stepping;
    logic stepDone;
    logic prechargeOn;

    assign stepping = (phase == BANDGAP) || (phase == PTAT);

    // Step lengths in clk cycles
    always_comb begin
        case (state)
            DIODE:            stepLen = (phase == PTAT) ? stepCountWidth'(16) : stepCountWidth'(8);
            BIGDIODE:         stepLen = stepCountWidth'(6);
            HCHARGE, LCHARGE: stepLen = stepCountWidth'(5);
            default:          stepLen = stepCountWidth'(1);
        endcase
    end

    assign stepDone = stepping && (state != PRECHARGESTEP) && (stepCount == stepLen - 1'b1);
    assign roundDone = stepDone && (state == OUTPUT);
    assign chopToggle = stepDone && (state == DIODE);
    assign ptatStepDone = chopToggle && (phase == PTAT);

    always_comb begin
        stateNext = state;
        afterNext = afterBlank;
        hChargedNext = hCharged;
        if (stepStart) begin
            stateNext = BLANKBIGDIODE;
            afterNext = BIGDIODE;
            hChargedNext = 1'b0;
        end else if (!stepping) begin
            stateNext = PRECHARGESTEP;
            afterNext = BIGDIODE;
            hChargedNext = 1'b0;
        end else if (stepDone) begin
            case (state)
                BLANKBIGDIODE: begin
                    stateNext = afterBlank;
                    if (afterBlank == BLANKDIODE) afterNext = DIODE;
                end
                BLANKDIODE: begin
                    stateNext = afterBlank;
                    if (afterBlank == BLANKBIGDIODE) afterNext = BIGDIODE;
                end
                BIGDIODE: begin
                    stateNext = BLANKBIGDIODE;
                    afterNext = BLANKDIODE;
                end
                DIODE: begin
                    stateNext = BLANKDIODE;
                    if (phase == PTAT) begin
                        afterNext = BLANKBIGDIODE;
                    end else begin
                        afterNext = hCharged ? LCHARGE : HCHARGE;
                    end
                end
                HCHARGE: begin
                    hChargedNext = 1'b1;
                    stateNext = BLANKBIGDIODE;
                    afterNext = BIGDIODE;
                end
                LCHARGE: begin
                    hChargedNext = 1'b0;
                    stateNext = OUTPUT;
                end
                OUTPUT: begin
                    stateNext = BLANKBIGDIODE;
                    afterNext = BIGDIODE;
                end
                default: stateNext = PRECHARGESTEP;
            endcase
        end
    end

    assign prechargeOn = (stateNext == PRECHARGESTEP) && (phase == PRECHARGE);

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            state <= PRECHARGESTEP;
            afterBlank <= BIGDIODE;
            hCharged <= 1'b0;
            stepCount <= '0;
            {PI1, PI2, PII1, PII2} <= 4'b0000;
            {PA, PB, PC, PD} <= 4'b0000;
            srcN <= 1'b0;
            snk <= 1'b0;
        end else begin
            state <= stateNext;
            afterBlank <= afterNext;
            hCharged <= hChargedNext;
            if (stepStart || stateNext != state) begin
                stepCount <= '0;
            end else if (stepping) begin
                stepCount <= stepCount + 1'b1;
            end
            // Blanking pre-closes the first switch of the coming step
            PI1 <= (stateNext == BIGDIODE) || (stateNext == BLANKBIGDIODE && afterNext == BIGDIODE);
            PI2 <= (stateNext == BIGDIODE);
            PII1 <= (stateNext == DIODE) || (stateNext == BLANKDIODE && afterNext == DIODE);
            PII2 <= (stateNext == DIODE);
            PA <= (stateNext == HCHARGE) || (stateNext == LCHARGE);
            PB <= (stateNext == HCHARGE) || (stateNext == OUTPUT) || prechargeOn;
            PC <= (stateNext == LCHARGE) || (stateNext == OUTPUT) || prechargeOn;
            PD <= (stateNext == OUTPUT) || prechargeOn;
            srcN <= (stateNext == BIGDIODE) && cmpSync;
            snk <= (stateNext == BIGDIODE) && !cmpSync;
        end
    end

    // Current steering only in the stepped phases, one direction at a time
    steerExclusive: assert property (
        @(posedge clk) disable iff (reset)
            (srcN || snk) |-> (!(srcN && snk) && (phase == BANDGAP || phase == PTAT))
    );

endmodule

// ==== hdl/phaseSequencer.sv ====
`timescale 1ns/1ps

module phaseSequencer
    import tempSensePkg::*;
#(
    parameter int measureCycles = 400,
    parameter int sleepCycles = 30,
    parameter int bandgapRounds = 10
) (
    input  logic clk,
    input  logic reset,
    input  logic roundDone,
    input  logic ptatStepDone,
    input  logic cmpSync,
    input  logic hasCredit,
    output parentState_t phase,
    output logic stepStart,
    output logic measureEnable,
    output logic chopPolarity,
    output logic clearCounts,
    output logic resultSend,
    output logic sBg2Cmp,
    output logic sBgCtrl,
    output logic sPtatCtrl,
    output logic sCap2Cmp,
    output logic sRef2Cmp,
    output logic sCapRst,
    output logic sPtatOut,
    output logic sRdisconN,
    output logic pwrUp,
    output logic preChrg
);

    localparam int prechargeCycles = 16;
    localparam int roundWidth = $clog2(bandgapRounds + 1);

    logic resetSync;
    parentState_t phaseNext;
    logic [stepCountWidth-1:0] timer;
    logic [roundWidth-1:0] roundCount;
    logic [2:0] ptatSteps;
    logic ptatEntryCmp;
    logic timerDone;
    logic lastRound;
    logic ptatExit;

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            resetSync <= 1'b1;
        end else begin
            resetSync <= 1'b0;
        end
    end

    // Timer holds at zero in the stepped phases
    always_comb begin
        case (phase)
            PRECHARGE: timerDone = (timer == stepCountWidth'(prechargeCycles - 1));
            MEASURE:   timerDone = (timer == stepCountWidth'(measureCycles - 1));
            SLEEP:     timerDone = (timer >= stepCountWidth'(sleepCycles - 1));
            default:   timerDone = 1'b1;
        endcase
    end

    assign lastRound = roundDone && (roundCount == roundWidth'(bandgapRounds - 1));
    // Exit on the fifth or later step once the comparator has flipped
    assign ptatExit = ptatStepDone && (ptatSteps >= 3'd4) && (cmpSync != ptatEntryCmp);

    always_comb begin
        phaseNext = phase;
        case (phase)
            PRECHARGE: if (timerDone) phaseNext = BANDGAP;
            BANDGAP:   if (lastRound) phaseNext = PTAT;
            PTAT:      if (ptatExit) phaseNext = MEASURE;
            MEASURE:   if (timerDone) phaseNext = SLEEP;
            // Credit must still be held after the last result was taken
            SLEEP:     if (timerDone && hasCredit && !resultSend) phaseNext = BANDGAP;
            default:   phaseNext = PRECHARGE;
        endcase
    end

    always_ff @(posedge clk or posedge resetSync) begin
        if (resetSync) begin
            phase <= PRECHARGE;
            timer <= '0;
            roundCount <= '0;
            ptatSteps <= '0;
            ptatEntryCmp <= 1'b0;
            chopPolarity <= 1'b0;
            stepStart <= 1'b0;
            clearCounts <= 1'b0;
            resultSend <= 1'b0;
            measureEnable <= 1'b0;
            sBg2Cmp <= 1'b0;
            sBgCtrl <= 1'b0;
            sPtatCtrl <= 1'b0;
            sCap2Cmp <= 1'b0;
            sRef2Cmp <= 1'b0;
            sCapRst <= 1'b0;
            sPtatOut <= 1'b0;
            sRdisconN <= 1'b0;
            pwrUp <= 1'b0;
            preChrg <= 1'b0;
        end else begin
            phase <= phaseNext;
            stepStart <= (phaseNext != phase) && (phaseNext == BANDGAP || phaseNext == PTAT);
            clearCounts <= (phaseNext == MEASURE) && (phase != MEASURE);
            resultSend <= (phase == MEASURE) && (phaseNext == SLEEP);
            measureEnable <= (phaseNext == MEASURE);

            if (phaseNext != phase) begin
                timer <= '0;
            end else if (!timerDone) begin
                timer <= timer + 1'b1;
            end

            if (phase != BANDGAP) begin
                roundCount <= '0;
            end else if (roundDone) begin
                roundCount <= roundCount + 1'b1;
            end

            // Entry level tracks the comparator until PTAT starts
            if (phase != PTAT) begin
                ptatSteps <= '0;
                ptatEntryCmp <= cmpSync;
            end else if (ptatStepDone && ptatSteps < 3'd4) begin
                ptatSteps <= ptatSteps + 1'b1;
            end

            if (ptatExit) begin
                chopPolarity <= cmpSync;
            end

            sBg2Cmp <= 1'b0;
            sBgCtrl <= 1'b0;
            sPtatCtrl <= 1'b0;
            sCap2Cmp <= 1'b0;
            sRef2Cmp <= 1'b0;
            sCapRst <= 1'b0;
            sPtatOut <= 1'b0;
            sRdisconN <= 1'b0;
            pwrUp <= 1'b1;
            preChrg <= 1'b0;
            case (phaseNext)
                PRECHARGE: begin
                    sBgCtrl <= 1'b1;
                    sPtatCtrl <= 1'b1;
                    sCapRst <= 1'b1;
                    sRdisconN <= 1'b1;
                    preChrg <= 1'b1;
                end
                BANDGAP: begin
                    sBgCtrl <= 1'b1;
                    sRdisconN <= 1'b1;
                    sBg2Cmp <= 1'b1;
                end
                PTAT: begin
                    sPtatCtrl <= 1'b1;
                    sBg2Cmp <= 1'b1;
                end
                MEASURE: begin
                    sPtatCtrl <= 1'b1;
                    sCap2Cmp <= 1'b1;
                    sRef2Cmp <= 1'b1;
                    sPtatOut <= 1'b1;
                end
                default: begin
                    sCapRst <= 1'b1;
                    sRdisconN <= 1'b1;
                    pwrUp <= 1'b0;
                end
            endcase
        end
    end

    // A result only leaves while the port still holds a credit
    sendNeedsCredit: assert property (
        @(posedge clk) disable iff (resetSync) resultSend |-> hasCredit
    );

endmodule

// ==== hdl/resultCreditPort.sv ====
`timescale 1ns/1ps

module resultCreditPort #(
    parameter int countWidth = 8,
    parameter int creditDepth = 2
) (
    input  logic clk,
    input  logic reset,
    input  logic resultSend,
    input  logic resultCredit,
    input  logic [countWidth-1:0] countIn1,
    input  logic [countWidth-1:0] countIn2,
    output logic hasCredit,
    output logic resultValid,
    output logic [countWidth-1:0] tmpCount1,
    output logic [countWidth-1:0] tmpCount2
);

    localparam int creditWidth = $clog2(creditDepth + 1);

    logic [creditWidth-1:0] credits;

    assign hasCredit = (credits != '0);

    // Send and return in the same cycle cancel out
    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            credits <= creditWidth'(creditDepth);
        end else if (resultSend && !resultCredit) begin
            credits <= credits - 1'b1;
        end else if (resultCredit && !resultSend && credits < creditWidth'(creditDepth)) begin
            credits <= credits + 1'b1;
        end
    end

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            resultValid <= 1'b0;
            tmpCount1 <= '0;
            tmpCount2 <= '0;
        end else begin
            resultValid <= resultSend;
            if (resultSend) begin
                tmpCount1 <= countIn1;
                tmpCount2 <= countIn2;
            end
        end
    end

    creditBound: assert property (
        @(posedge clk) disable iff (reset) credits <= creditWidth'(creditDepth)
    );

endmodule

// ==== hdl/tempSensePkg.sv ====
package tempSensePkg;

    // Phases of the parent sequencer
    typedef enum logic [2:0] {
        SLEEP,
        PRECHARGE,
        BANDGAP,
        PTAT,
        MEASURE
    } parentState_t;

    // Steps of the diode and capacitor network
    typedef enum logic [2:0] {
        PRECHARGESTEP,
        DIODE,
        BIGDIODE,
        HCHARGE,
        LCHARGE,
        OUTPUT,
        BLANKDIODE,
        BLANKBIGDIODE
    } childState_t;

    // Width of step and phase timers
    localparam int stepCountWidth = 9;

endpackage

// ==== hdl/tempSenseTop.sv ====
`timescale 1ns/1ps

module tempSenseTop
    import tempSensePkg::*;
#(
    parameter int countWidth = 8,
    parameter int measureCycles = 400,
    parameter int sleepCycles = 30,
    parameter int bandgapRounds = 10,
    parameter int creditDepth = 2
) (
    input  logic clk,
    input  logic reset,
    input  logic cmp,
    input  logic resultCredit,
    output logic PI1,
    output logic PI2,
    output logic PII1,
    output logic PII2,
    output logic PA,
    output logic PB,
    output logic PC,
    output logic PD,
    output logic sBg2Cmp,
    output logic sBgCtrl,
    output logic sPtatCtrl,
    output logic sCap2Cmp,
    output logic sRef2Cmp,
    output logic sCapRst,
    output logic sPtatOut,
    output logic sRdisconN,
    output logic srcN,
    output logic snk,
    output logic cmpP1,
    output logic cmpP2,
    output logic pwrUp,
    output logic preChrg,
    output logic resultValid,
    output logic [countWidth-1:0] tmpCount1,
    output logic [countWidth-1:0] tmpCount2
);

    parentState_t phase;
    logic stepStart;
    logic roundDone;
    logic ptatStepDone;
    logic chopToggle;
    logic cmpSync;
    logic measureEnable;
    logic chopPolarity;
    logic clearCounts;
    logic resultSend;
    logic hasCredit;
    logic [countWidth-1:0] liveCount1;
    logic [countWidth-1:0] liveCount2;

    phaseSequencer #(
        .measureCycles(measureCycles),
        .sleepCycles(sleepCycles),
        .bandgapRounds(bandgapRounds)
    ) sequencer (
        .clk(clk),
        .reset(reset),
        .roundDone(roundDone),
        .ptatStepDone(ptatStepDone),
        .cmpSync(cmpSync),
        .hasCredit(hasCredit),
        .phase(phase),
        .stepStart(stepStart),
        .measureEnable(measureEnable),
        .chopPolarity(chopPolarity),
        .clearCounts(clearCounts),
        .resultSend(resultSend),
        .sBg2Cmp(sBg2Cmp),
        .sBgCtrl(sBgCtrl),
        .sPtatCtrl(sPtatCtrl),
        .sCap2Cmp(sCap2Cmp),
        .sRef2Cmp(sRef2Cmp),
        .sCapRst(sCapRst),
        .sPtatOut(sPtatOut),
        .sRdisconN(sRdisconN),
        .pwrUp(pwrUp),
        .preChrg(preChrg)
    );

    diodeStepper stepper (
        .clk(clk),
        .reset(reset),
        .stepStart(stepStart),
        .cmpSync(cmpSync),
        .phase(phase),
        .PI1(PI1),
        .PI2(PI2),
        .PII1(PII1),
        .PII2(PII2),
        .PA(PA),
        .PB(PB),
        .PC(PC),
        .PD(PD),
        .srcN(srcN),
        .snk(snk),
        .roundDone(roundDone),
        .ptatStepDone(ptatStepDone),
        .chopToggle(chopToggle)
    );

    cmpEdgeCounter #(
        .countWidth(countWidth)
    ) edgeCounter (
        .clk(clk),
        .reset(reset),
        .cmp(cmp),
        .measureEnable(measureEnable),
        .chopPolarity(chopPolarity),
        .clearCounts(clearCounts),
        .chopToggle(chopToggle),
        .cmpSync(cmpSync),
        .tmpCount1(liveCount1),
        .tmpCount2(liveCount2),
        .cmpP1(cmpP1),
        .cmpP2(cmpP2)
    );

    resultCreditPort #(
        .countWidth(countWidth),
        .creditDepth(creditDepth)
    ) resultPort (
        .clk(clk),
        .reset(reset),
        .resultSend(resultSend),
        .resultCredit(resultCredit),
        .countIn1(liveCount1),
        .countIn2(liveCount2),
        .hasCredit(hasCredit),
        .resultValid(resultValid),
        .tmpCount1(tmpCount1),
        .tmpCount2(tmpCount2)
    );

endmodule

// ==== tempSense.f ====
hdl/tempSensePkg.sv
hdl/cmpEdgeCounter.sv
hdl/diodeStepper.sv
hdl/phaseSequencer.sv
hdl/resultCreditPort.sv
hdl/tempSenseTop.sv
testbench/tbClock.sv
testbench/tbTempSense.sv

// ==== testbench/tbClock.sv ====
`timescale 1ns/1ps

module tbClock #(
    parameter int halfPeriod = 10
) (
    output logic clk
);

    // 20 ns period with the default half period
    initial begin
        clk = 1'b0;
        forever #(halfPeriod) clk = ~clk;
    end

endmodule

// ==== testbench/tbTempSense.sv ====
`timescale 1ns/1ps

module tbTempSense;

    localparam int countWidth = 8;
    localparam int measureCycles = 120;
    localparam int sleepCycles = 10;
    localparam int bandgapRounds = 2;
    localparam int creditDepth = 1;
    localparam int numRows = 6;
    // A full sensor loop takes a few hundred cycles
    localparam int phaseTimeout = 2000;
    localparam int stallCycles = 1500;
    localparam int pulseStart = 5;
    localparam int pulseSpacing = 6;

    logic clk;
    logic reset;
    logic cmp;
    logic resultCredit;
    logic PI1;
    logic PI2;
    logic PII1;
    logic PII2;
    logic PA;
    logic PB;
    logic PC;
    logic PD;
    logic sBg2Cmp;
    logic sBgCtrl;
    logic sPtatCtrl;
    logic sCap2Cmp;
    logic sRef2Cmp;
    logic sCapRst;
    logic sPtatOut;
    logic sRdisconN;
    logic srcN;
    logic snk;
    logic cmpP1;
    logic cmpP2;
    logic pwrUp;
    logic preChrg;
    logic resultValid;
    logic [countWidth-1:0] tmpCount1;
    logic [countWidth-1:0] tmpCount2;

    // Stimulus and expected results, one entry per row
    int entryLevel [numRows];
    int switchLevel [numRows];
    int pulseCount [numRows];
    int giveCredit [numRows];
    int expectResult [numRows];
    int expCount1 [numRows];
    int expCount2 [numRows];
    int rowsFilled;
    integer seed;
    int errorCount;
    int checkCount;
    int resultPulses;
    bit timedOut;

    tbClock clockGen (
        .clk(clk)
    );

    tempSenseTop #(
        .countWidth(countWidth),
        .measureCycles(measureCycles),
        .sleepCycles(sleepCycles),
        .bandgapRounds(bandgapRounds),
        .creditDepth(creditDepth)
    ) uut (.*);

    task automatic checkEqual(input string what, input int got, input int expected);
        checkCount++;
        assert (got == expected) else begin
            $display("MISMATCH at %0t ns: %s is %0d, expected %0d", $time, what, got, expected);
            errorCount++;
        end
    endtask

    task automatic addRow(input int entry, input int switchTo, input int pulses,
                          input int credit, input int result, input int exp1, input int exp2);
        entryLevel[rowsFilled] = entry;
        switchLevel[rowsFilled] = switchTo;
        pulseCount[rowsFilled] = pulses;
        giveCredit[rowsFilled] = credit;
        expectResult[rowsFilled] = result;
        expCount1[rowsFilled] = exp1;
        expCount2[rowsFilled] = exp2;
        rowsFilled++;
    endtask

    // Count lands in tmpCount1 when the level at PTAT exit is high
    task automatic addRandomRow(input int entry, input int credit);
        int pulses;
        pulses = $unsigned($random(seed)) % 16;
        addRow(entry, 1 - entry, pulses, credit, 1,
               (entry == 0) ? pulses : 0, (entry == 0) ? 0 : pulses);
    endtask

    task automatic buildTable();
        rowsFilled = 0;
        addRow(0, 1, 7, 1, 1, 7, 0);
        addRow(1, 0, 9, 0, 1, 0, 9);
        // Out of credit, so no window may open
        addRow(0, 0, 0, 1, 0, 0, 0);
        addRandomRow(0, 1);
        addRandomRow(1, 1);
        addRow(0, 1, 0, 1, 1, 0, 0);
    endtask

    task automatic checkResetState();
        checkEqual("diode and capacitor switches", {PI1, PI2, PII1, PII2, PA, PB, PC, PD}, 0);
        checkEqual("analog enables",
                   {sBg2Cmp, sBgCtrl, sPtatCtrl, sCap2Cmp, sRef2Cmp, sCapRst, sPtatOut,
                    sRdisconN}, 0);
        checkEqual("srcN and snk", {srcN, snk}, 0);
        checkEqual("pwrUp and preChrg", {pwrUp, preChrg}, 0);
        checkEqual("resultValid", resultValid, 0);
        checkEqual("tmpCount1", tmpCount1, 0);
        checkEqual("tmpCount2", tmpCount2, 0);
    endtask

    task automatic waitPtatEntry(output bit found);
        int waited;
        waited = 0;
        found = 1'b0;
        while (!found && waited < phaseTimeout) begin
            @(negedge clk);
            waited++;
            found = sPtatCtrl && sBg2Cmp;
        end
    endtask

    // A diode step ends when PII2 falls
    task automatic waitDiodeSteps(input int steps, output bit found);
        int waited;
        int seen;
        logic lastPII2;
        waited = 0;
        seen = 0;
        lastPII2 = PII2;
        while (seen < steps && waited < phaseTimeout) begin
            @(negedge clk);
            waited++;
            if (lastPII2 && !PII2) seen++;
            lastPII2 = PII2;
        end
        found = (seen == steps);
    endtask

    task automatic waitMeasureStart(input int limit, output bit found);
        int waited;
        waited = 0;
        found = 1'b0;
        while (!found && waited < limit) begin
            @(negedge clk);
            waited++;
            found = sCap2Cmp;
        end
    endtask

    task automatic runMeasureRow(input int r);
        bit found;
        int k;
        int highCycles;
        int pulseEnd;
        logic chopStart;
        cmp = (entryLevel[r] != 0);
        waitPtatEntry(found);
        if (!found) begin
            $display("Timed out waiting for the PTAT phase in row %0d", r);
            timedOut = 1'b1;
            return;
        end
        waitDiodeSteps(5, found);
        if (!found) begin
            $display("Timed out waiting for five PTAT diode steps in row %0d", r);
            timedOut = 1'b1;
            return;
        end
        cmp = (switchLevel[r] != 0);
        waitMeasureStart(phaseTimeout, found);
        if (!found) begin
            $display("Timed out waiting for the measurement window in row %0d", r);
            timedOut = 1'b1;
            return;
        end
        chopStart = cmpP1;
        highCycles = 1;
        k = 0;
        pulseEnd = pulseStart + pulseSpacing * pulseCount[r];
        // Each pulse is 3 cycles low then 3 cycles high
        while (sCap2Cmp && k < phaseTimeout) begin
            if (k >= pulseStart && k < pulseEnd) begin
                cmp = ((k - pulseStart) % pulseSpacing) >= 3;
            end
            @(negedge clk);
            k++;
            if (sCap2Cmp) highCycles++;
        end
        if (sCap2Cmp) begin
            $display("Measurement window never closed in row %0d", r);
            timedOut = 1'b1;
            return;
        end
        checkEqual("sCap2Cmp high cycles", highCycles, measureCycles);
        checkEqual("cmpP1 toggle parity", (cmpP1 != chopStart) ? 1 : 0, pulseCount[r] % 2);
        checkEqual("resultValid as sCap2Cmp falls", resultValid, 0);
        @(negedge clk);
        checkEqual("resultValid after sCap2Cmp falls", resultValid, 1);
        checkEqual("tmpCount1", tmpCount1, expCount1[r]);
        checkEqual("tmpCount2", tmpCount2, expCount2[r]);
        @(negedge clk);
        checkEqual("resultValid one cycle later", resultValid, 0);
    endtask

    task automatic runStalledRow(input int r);
        bit found;
        int waited;
        int pulsesBefore;
        pulsesBefore = resultPulses;
        cmp = (entryLevel[r] != 0);
        waited = 0;
        found = 1'b0;
        // Comparator flips now and then so a wrongly started PTAT phase can end
        while (!found && waited < stallCycles) begin
            @(negedge clk);
            waited++;
            if (waited % 97 == 0) cmp = !cmp;
            found = sCap2Cmp;
        end
        checkCount++;
        assert (!found) else begin
            $display("Measurement window opened at %0t ns in row %0d with no credit left",
                     $time, r);
            errorCount++;
        end
        checkEqual("results while out of credit", resultPulses - pulsesBefore, 0);
    endtask

    task automatic returnCredit();
        @(negedge clk);
        resultCredit = 1'b1;
        @(negedge clk);
        resultCredit = 1'b0;
    endtask

    always @(negedge clk) begin
        if (!reset) begin
            assert (cmpP2 == !cmpP1) else begin
                $display("MISMATCH at %0t ns: cmpP2 is not the complement of cmpP1", $time);
                errorCount++;
            end
            assert (!(srcN && snk)) else begin
                $display("MISMATCH at %0t ns: srcN and snk are high together", $time);
                errorCount++;
            end
            if (resultValid) resultPulses++;
        end
    end

    initial begin
        int r;
        int errorsBefore;
        seed = 34507;
        errorCount = 0;
        checkCount = 0;
        resultPulses = 0;
        timedOut = 1'b0;
        reset = 1'b1;
        cmp = 1'b0;
        resultCredit = 1'b0;
        buildTable();
        repeat (3) @(negedge clk);
        checkResetState();
        reset = 1'b0;
        r = 0;
        while (r < numRows && !timedOut) begin
            errorsBefore = errorCount;
            if (expectResult[r] != 0) begin
                runMeasureRow(r);
            end else begin
                runStalledRow(r);
            end
            if (!timedOut && giveCredit[r] != 0) begin
                returnCredit();
            end
            $display("row %0d: pulses %0d, result expected %0d, errors %0d%s", r,
                     pulseCount[r], expectResult[r], errorCount - errorsBefore,
                     timedOut ? ", timed out" : "");
            r++;
        end
        $display("checks %0d, errors %0d, timeouts %0d", checkCount, errorCount,
                 timedOut ? 1 : 0);
        if (errorCount == 0 && !timedOut) begin
            $display("STATUS: PASS");
        end else begin
            $display("STATUS: FAIL");
        end
        $finish;
    end

endmodule
